// File: design/afu_config.svh
// AFU configuration macros
// Datapath widths, MMIO bus widths and soft-reset length

`ifndef AFU_CONFIG_SVH
`define AFU_CONFIG_SVH

// Base, stride and accumulator width
`define AFU_ACC_WIDTH         32
// Term count width
`define AFU_COUNT_WIDTH       16

`define AFU_MMIO_ADDR_WIDTH   8
`define AFU_MMIO_DATA_WIDTH   64

// Internal reset hold time after a soft reset, in cycles
`define AFU_SOFT_RESET_CYCLES 4

`endif

// File: design/afu_pkg.sv
// AFU shared types
// Job opcodes, MMIO register map, FSM states and error bit positions

`default_nettype none

`include "afu_config.svh"

package afu_pkg;

  // Job opcodes; code 2'b11 is illegal
  typedef enum logic [1:0] {
    JOB_NOP   = 2'd0,
    JOB_START = 2'd1,
    JOB_RESET = 2'd2
  } job_cmd_e;

  // MMIO register map
  typedef enum logic [`AFU_MMIO_ADDR_WIDTH-1:0] {
    REG_BASE   = 'h00,
    REG_STRIDE = 'h08,
    REG_COUNT  = 'h10,
    REG_RESULT = 'h18,
    REG_ERROR  = 'h20,
    REG_STATUS = 'h28
  } mmio_reg_e;

  typedef enum logic {
    CU_IDLE,
    CU_RUN
  } cu_state_e;

  typedef enum logic {
    JOB_IDLE,
    JOB_RUNNING
  } job_state_e;

  // Sticky error word layout
  localparam int ERR_MMIO_ADDRESS = 0;
  localparam int ERR_JOB_COMMAND  = 1;
  localparam int ERR_ACC_OVERFLOW = 2;
  localparam int ERR_WIDTH        = 3;

endpackage

`default_nettype wire

// File: design/afu_top.sv
// AFU top level
// Connects job control, MMIO registers, error collector, reset control
// and the compute unit to the plain host ports

`default_nettype none

`include "afu_config.svh"

module afu_top (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            job_valid,
  input  afu_pkg::job_cmd_e               job_command,
  input  logic                            mmio_valid,
  input  logic                            mmio_write,
  input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
  input  logic [`AFU_MMIO_DATA_WIDTH-1:0] mmio_wdata,
  output logic                            job_running,
  output logic                            job_done,
  output logic                            mmio_ack,
  output logic [`AFU_MMIO_DATA_WIDTH-1:0] mmio_rdata,
  output logic                            mmio_error
);

  logic                          rst_int_n;
  logic                          soft_reset;
  logic                          command_error;
  logic                          address_error;
  logic                          error_clear;
  logic [afu_pkg::ERR_WIDTH-1:0] error_word;

  cu_ctrl_if cu ();

  ////////////////////////////////////////////////////////////////////////////
  // Reset
  ////////////////////////////////////////////////////////////////////////////

  reset_control i_reset_control (
    .clock      (clock),
    .rst_n      (rst_n),
    .soft_reset (soft_reset),
    .rst_int_n  (rst_int_n)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Job and MMIO
  ////////////////////////////////////////////////////////////////////////////

  job_control i_job_control (
    .clock         (clock),
    .rst_n         (rst_int_n),
    .job_valid     (job_valid),
    .job_command   (job_command),
    .cu            (cu.ctl),
    .job_running   (job_running),
    .job_done      (job_done),
    .command_error (command_error),
    .soft_reset    (soft_reset)
  );

  mmio_regs i_mmio_regs (
    .clock         (clock),
    .rst_n         (rst_int_n),
    .mmio_valid    (mmio_valid),
    .mmio_write    (mmio_write),
    .mmio_address  (mmio_address),
    .mmio_wdata    (mmio_wdata),
    .job_running   (job_running),
    .error_word    (error_word),
    .cu            (cu.cfg),
    .mmio_ack      (mmio_ack),
    .mmio_error    (mmio_error),
    .address_error (address_error),
    .error_clear   (error_clear),
    .mmio_rdata    (mmio_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Errors and compute
  ////////////////////////////////////////////////////////////////////////////

  error_control i_error_control (
    .clock         (clock),
    .rst_n         (rst_int_n),
    .address_error (address_error),
    .command_error (command_error),
    .cu_done       (cu.done),
    .cu_overflow   (cu.overflow),
    .error_clear   (error_clear),
    .error_word    (error_word)
  );

  compute_unit i_compute_unit (
    .clock (clock),
    .rst_n (rst_int_n),
    .cu    (cu.unit)
  );

endmodule

`default_nettype wire

// File: design/compute_unit.sv
// Compute unit
// Accumulates base + i*stride for i in 0..count-1, one term per cycle,
// and records any carry out of the accumulator

`default_nettype none

`include "afu_config.svh"

module compute_unit (
  input  logic   clock,
  input  logic   rst_n,
  cu_ctrl_if.unit cu
);

  import afu_pkg::*;

  cu_state_e                   state_q;
  logic [`AFU_ACC_WIDTH-1:0]   acc_q;
  logic [`AFU_ACC_WIDTH-1:0]   term_q;
  logic [`AFU_ACC_WIDTH-1:0]   stride_q;
  logic [`AFU_COUNT_WIDTH-1:0] remaining_q;
  logic                        overflow_q;
  logic                        done_q;
  logic [`AFU_ACC_WIDTH:0]     sum;

  // Extra top bit catches the carry
  assign sum = {1'b0, acc_q} + {1'b0, term_q};

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= CU_IDLE;
      acc_q       <= '0;
      term_q      <= '0;
      stride_q    <= '0;
      remaining_q <= '0;
      overflow_q  <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        CU_IDLE: begin
          if (cu.start) begin
            state_q     <= CU_RUN;
            acc_q       <= '0;
            overflow_q  <= 1'b0;
            term_q      <= cu.base;
            stride_q    <= cu.stride;
            remaining_q <= cu.count;
          end
        end
        CU_RUN: begin
          if (remaining_q != '0) begin
            acc_q       <= sum[`AFU_ACC_WIDTH-1:0];
            overflow_q  <= overflow_q | sum[`AFU_ACC_WIDTH];
            term_q      <= term_q + stride_q;
            remaining_q <= remaining_q - 1'b1;
          end
          // Last term, or nothing to add for a zero count
          if (remaining_q <= 1) begin
            state_q <= CU_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= CU_IDLE;
      endcase
    end
  end

  assign cu.busy     = (state_q == CU_RUN);
  assign cu.done     = done_q;
  assign cu.result   = acc_q;
  assign cu.overflow = overflow_q;

endmodule

`default_nettype wire

// File: design/cu_ctrl_if.sv
// Compute unit control interface
// Work description, start strobe and completion status

`default_nettype none

`include "afu_config.svh"

interface cu_ctrl_if;

  logic [`AFU_ACC_WIDTH-1:0]   base;
  logic [`AFU_ACC_WIDTH-1:0]   stride;
  logic [`AFU_COUNT_WIDTH-1:0] count;
  logic                        start;
  logic                        busy;
  logic                        done;
  logic [`AFU_ACC_WIDTH-1:0]   result;
  logic                        overflow;

  // Register block side
  modport cfg (output base, stride, count, input result, busy);
  // Job controller side
  modport ctl (output start, input done, busy);
  // Compute unit side
  modport unit (input base, stride, count, start, output busy, done, result, overflow);

endinterface

`default_nettype wire

// File: design/error_control.sv
// Error collector
// Sticky error flags, cleared by a host write to the error register

`default_nettype none

module error_control (
  input  logic                          clock,
  input  logic                          rst_n,
  input  logic                          address_error,
  input  logic                          command_error,
  input  logic                          cu_done,
  input  logic                          cu_overflow,
  input  logic                          error_clear,
  output logic [afu_pkg::ERR_WIDTH-1:0] error_word
);

  import afu_pkg::*;

  logic [ERR_WIDTH-1:0] new_errors;
  logic [ERR_WIDTH-1:0] error_q;

  always_comb begin
    new_errors                   = '0;
    new_errors[ERR_MMIO_ADDRESS] = address_error;
    new_errors[ERR_JOB_COMMAND]  = command_error;
    // Overflow only counts once the job result is final
    new_errors[ERR_ACC_OVERFLOW] = cu_done && cu_overflow;
  end

  // New errors win over a clear in the same cycle
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      error_q <= '0;
    end else begin
      error_q <= (error_clear ? '0 : error_q) | new_errors;
    end
  end

  assign error_word = error_q;

endmodule

`default_nettype wire

// File: design/job_control.sv
// Job control
// Decodes job commands, launches the compute unit and tracks the
// running job until the unit reports done

`default_nettype none

module job_control (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             job_valid,
  input  afu_pkg::job_cmd_e job_command,
  cu_ctrl_if.ctl           cu,
  output logic             job_running,
  output logic             job_done,
  output logic             command_error,
  output logic             soft_reset
);

  import afu_pkg::*;

  job_state_e state_q;
  logic       start_q;
  logic       done_q;
  logic       cmd_err_q;
  logic       soft_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= JOB_IDLE;
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      cmd_err_q <= 1'b0;
      soft_q    <= 1'b0;
    end else begin
      // All outputs below are single-cycle pulses
      start_q   <= 1'b0;
      done_q    <= 1'b0;
      cmd_err_q <= 1'b0;
      soft_q    <= 1'b0;

      if (state_q == JOB_RUNNING && cu.done) begin
        state_q <= JOB_IDLE;
        done_q  <= 1'b1;
      end

      if (job_valid) begin
        case (job_command)
          JOB_NOP: ;
          JOB_START: begin
            // Only one job in flight
            if (state_q == JOB_IDLE && !cu.busy) begin
              state_q <= JOB_RUNNING;
              start_q <= 1'b1;
            end else begin
              cmd_err_q <= 1'b1;
            end
          end
          JOB_RESET: soft_q <= 1'b1;
          default:   cmd_err_q <= 1'b1;
        endcase
      end
    end
  end

  assign cu.start      = start_q;
  assign job_running   = (state_q == JOB_RUNNING);
  assign job_done      = done_q;
  assign command_error = cmd_err_q;
  assign soft_reset    = soft_q;

endmodule

`default_nettype wire

// File: design/mmio_regs.sv
// MMIO register block
// Holds the work description and returns result, error and status
// words. Every access is acknowledged one cycle after its strobe

`default_nettype none

`include "afu_config.svh"

module mmio_regs (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            mmio_valid,
  input  logic                            mmio_write,
  input  logic [`AFU_MMIO_ADDR_WIDTH-1:0] mmio_address,
  input  logic [`AFU_MMIO_DATA_WIDTH-1:0] mmio_wdata,
  input  logic                            job_running,
  input  logic [afu_pkg::ERR_WIDTH-1:0]   error_word,
  cu_ctrl_if.cfg                          cu,
  output logic                            mmio_ack,
  output logic                            mmio_error,
  output logic                            address_error,
  output logic                            error_clear,
  output logic [`AFU_MMIO_DATA_WIDTH-1:0] mmio_rdata
);

  import afu_pkg::*;

  localparam int data_width = `AFU_MMIO_DATA_WIDTH;

  logic [`AFU_ACC_WIDTH-1:0]   base_q;
  logic [`AFU_ACC_WIDTH-1:0]   stride_q;
  logic [`AFU_COUNT_WIDTH-1:0] count_q;
  logic                        ack_q;
  logic                        err_q;
  logic [data_width-1:0]       rdata_q;
  logic                        addr_hit;
  logic                        read_only;
  logic                        access_bad;
  logic [data_width-1:0]       read_value;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    addr_hit   = 1'b1;
    read_only  = 1'b0;
    read_value = '0;
    case (mmio_address)
      REG_BASE:   read_value = data_width'(base_q);
      REG_STRIDE: read_value = data_width'(stride_q);
      REG_COUNT:  read_value = data_width'(count_q);
      REG_RESULT: begin
        read_only  = 1'b1;
        read_value = data_width'(cu.result);
      end
      REG_ERROR:  read_value = data_width'(error_word);
      REG_STATUS: begin
        read_only  = 1'b1;
        // Bit 1 mirrors compute unit activity
        read_value = data_width'({cu.busy, job_running});
      end
      default:    addr_hit = 1'b0;
    endcase
  end

  assign access_bad    = !addr_hit || (mmio_write && read_only);
  assign address_error = mmio_valid && access_bad;
  // Writing REG_ERROR clears the sticky flags
  assign error_clear   = mmio_valid && mmio_write && (mmio_address == REG_ERROR);

  ////////////////////////////////////////////////////////////////////////////
  // Configuration registers and response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      base_q   <= '0;
      stride_q <= '0;
      count_q  <= '0;
      ack_q    <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      if (mmio_valid && mmio_write) begin
        case (mmio_address)
          REG_BASE:   base_q   <= mmio_wdata[`AFU_ACC_WIDTH-1:0];
          REG_STRIDE: stride_q <= mmio_wdata[`AFU_ACC_WIDTH-1:0];
          REG_COUNT:  count_q  <= mmio_wdata[`AFU_COUNT_WIDTH-1:0];
          default: ;
        endcase
      end
      ack_q   <= mmio_valid;
      err_q   <= address_error;
      rdata_q <= (mmio_valid && !mmio_write && !access_bad) ? read_value : '0;
    end
  end

  assign cu.base    = base_q;
  assign cu.stride  = stride_q;
  assign cu.count   = count_q;
  assign mmio_ack   = ack_q;
  assign mmio_error = err_q;
  assign mmio_rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/reset_control.sv
// Reset control
// Synchronizes the external reset and stretches soft-reset requests

`default_nettype none

`include "afu_config.svh"

module reset_control (
  input  logic clock,
  input  logic rst_n,
  input  logic soft_reset,
  output logic rst_int_n
);

  localparam int cnt_width = $clog2(`AFU_SOFT_RESET_CYCLES + 1);

  logic [1:0]           sync_q;
  logic [cnt_width-1:0] soft_count;

  // Assert immediately, release after two clean edges
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      sync_q     <= '0;
      soft_count <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
      if (soft_reset) begin
        soft_count <= cnt_width'(`AFU_SOFT_RESET_CYCLES);
      end else if (soft_count != '0) begin
        soft_count <= soft_count - 1'b1;
      end
    end
  end

  // Held low while the soft-reset counter runs
  assign rst_int_n = sync_q[1] & (soft_count == '0);

endmodule

`default_nettype wire

// File: filelist.f
+incdir+design
design/afu_pkg.sv
design/cu_ctrl_if.sv
design/reset_control.sv
design/job_control.sv
design/mmio_regs.sv
design/error_control.sv
design/compute_unit.sv
design/afu_top.sv
testbench/afu_props.sv
testbench/afu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the AFU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module afu_tb -f filelist.f -o afu_sim

# The log decides the result
./obj_dir/afu_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "Simulation stopped without a result"
  exit 1
fi
echo "Simulation passed"

// File: testbench/afu_patterns.txt
// Columns: op addr data flag, all hex. op 1 write, 2 read and expect data,
// 3 bad access (flag 1 = write), 4 start (addr = command issued mid-run,
// data = expected result, flag = expected overflow), 5 soft reset,
// 6 illegal command, 0 end
1 00 5 0          // base
1 08 3 0          // stride
1 10 a 0          // count
2 00 5 0
2 08 3 0
2 10 a 0
4 00 b9 0         // 5 + 8 + ... + 32
2 28 0 0          // idle again
1 10 0 0
4 00 0 0          // zero count
1 00 fffffff0 0
1 08 10 0
1 10 4 0
4 00 20 1         // carry on the third term
2 20 4 0
1 20 0 0          // clear errors
2 20 0 0
3 30 0 0          // unmapped read
3 18 1234 1       // write to result
2 20 1 0
1 20 0 0
1 00 7 0
1 10 5 0
4 01 c3 0         // second start while running
2 20 2 0
1 20 0 0
6 00 0 0
2 20 2 0
5 00 0 0
2 00 0 0
2 08 0 0
2 10 0 0
2 18 0 0
2 20 0 0
2 28 0 0
0 00 0 0

// File: testbench/afu_props.sv
// AFU protocol properties
// Checks the MMIO ack and job done pulses and quiet outputs during reset

`default_nettype none

module afu_props (
  input logic clock,
  input logic rst_n,
  input logic job_running,
  input logic job_done,
  input logic mmio_ack,
  input logic mmio_error
);

  // Ack is a single-cycle pulse
  ack_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
    mmio_ack |=> !mmio_ack)
    else $error("mmio_ack high for two cycles in a row");

  done_after_running: assert property (@(posedge clock) disable iff (!rst_n)
    job_done |-> $past(job_running))
    else $error("job_done without job_running in the cycle before");

  quiet_in_reset: assert property (@(posedge clock)
    !rst_n |-> !(job_running || job_done || mmio_ack || mmio_error))
    else $error("output active while rst_n is low");

endmodule

bind afu_top afu_props i_afu_props (
  .clock       (clock),
  .rst_n       (rst_n),
  .job_running (job_running),
  .job_done    (job_done),
  .mmio_ack    (mmio_ack),
  .mmio_error  (mmio_error)
);

`default_nettype wire

// File: testbench/afu_tb.sv
// AFU testbench
// Replays MMIO, job and reset patterns from a data file against the
// top level and checks each response against values worked out here

`default_nettype none

`include "afu_config.svh"

module afu_tb;

  import afu_pkg::*;

  localparam int max_patterns = 64;
  localparam int addr_width   = `AFU_MMIO_ADDR_WIDTH;
  localparam int data_width   = `AFU_MMIO_DATA_WIDTH;
  localparam int acc_width    = `AFU_ACC_WIDTH;

  // Pattern opcodes, first column of the data file
  localparam logic [3:0] op_end     = 4'd0;
  localparam logic [3:0] op_write   = 4'd1;
  localparam logic [3:0] op_read    = 4'd2;
  localparam logic [3:0] op_bad     = 4'd3;
  localparam logic [3:0] op_start   = 4'd4;
  localparam logic [3:0] op_soft    = 4'd5;
  localparam logic [3:0] op_illegal = 4'd6;

  logic                        clock;
  logic                        rst_n;
  logic                        job_valid;
  job_cmd_e                    job_command;
  logic                        mmio_valid;
  logic                        mmio_write;
  logic [addr_width-1:0]       mmio_address;
  logic [data_width-1:0]       mmio_wdata;
  logic                        job_running;
  logic                        job_done;
  logic                        mmio_ack;
  logic [data_width-1:0]       mmio_rdata;
  logic                        mmio_error;

  logic [63:0]                 pattern_mem [0:4*max_patterns-1];
  int                          pattern_count;
  logic                        patterns_loaded;

  // Host-side copy of the configuration registers
  logic [acc_width-1:0]        base_model;
  logic [acc_width-1:0]        stride_model;
  logic [`AFU_COUNT_WIDTH-1:0] count_model;

  afu_top i_afu_top (
    .clock        (clock),
    .rst_n        (rst_n),
    .job_valid    (job_valid),
    .job_command  (job_command),
    .mmio_valid   (mmio_valid),
    .mmio_write   (mmio_write),
    .mmio_address (mmio_address),
    .mmio_wdata   (mmio_wdata),
    .job_running  (job_running),
    .job_done     (job_done),
    .mmio_ack     (mmio_ack),
    .mmio_rdata   (mmio_rdata),
    .mmio_error   (mmio_error)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [data_width-1:0] got,
                             input logic [data_width-1:0] expected);
    assert (got === expected) else
      report_failure($sformatf("mismatch at %0t: %s expected %h got %h",
                               $time, name, expected, got));
  endtask

  // Sum of base + i*stride over count terms, carry in the top bit
  function automatic logic [acc_width:0] series_sum();
    logic [acc_width-1:0] acc;
    logic [acc_width-1:0] term;
    logic [acc_width:0]   wide;
    logic                 carry;
    acc   = '0;
    term  = base_model;
    carry = 1'b0;
    for (int i = 0; i < int'(count_model); i++) begin
      wide  = {1'b0, acc} + {1'b0, term};
      carry = carry | wide[acc_width];
      acc   = wide[acc_width-1:0];
      term  = term + stride_model;
    end
    return {carry, acc};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // MMIO and job stimulus
  ////////////////////////////////////////////////////////////////////////////

  // One access; the ack must follow the strobe by exactly one cycle
  task automatic mmio_access(input logic write, input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] wdata,
                             output logic [data_width-1:0] rdata, output logic err);
    @(negedge clock);
    assert (mmio_ack == 1'b0) else
      report_failure($sformatf("mmio_ack already high before access at %0t", $time));
    mmio_valid   = 1'b1;
    mmio_write   = write;
    mmio_address = addr;
    mmio_wdata   = wdata;
    @(negedge clock);
    mmio_valid = 1'b0;
    mmio_write = 1'b0;
    assert (mmio_ack == 1'b1) else
      report_failure($sformatf("no mmio_ack one cycle after mmio_valid at %0t, address %h",
                               $time, addr));
    rdata = mmio_rdata;
    err   = mmio_error;
  endtask

  task automatic write_register(input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] data);
    logic [data_width-1:0] rdata;
    logic                  err;
    mmio_access(1'b1, addr, data, rdata, err);
    check_value("mmio_error", data_width'(err), '0);
    if (addr == REG_BASE) begin
      base_model = data[acc_width-1:0];
    end else if (addr == REG_STRIDE) begin
      stride_model = data[acc_width-1:0];
    end else if (addr == REG_COUNT) begin
      count_model = data[`AFU_COUNT_WIDTH-1:0];
    end
  endtask

  task automatic read_register(input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] expected);
    logic [data_width-1:0] rdata;
    logic                  err;
    mmio_access(1'b0, addr, '0, rdata, err);
    check_value("mmio_error", data_width'(err), '0);
    check_value($sformatf("mmio_rdata at address %h", addr), rdata, expected);
  endtask

  // Errored accesses pulse mmio_error and return zero
  task automatic bad_access(input logic write, input logic [addr_width-1:0] addr,
                            input logic [data_width-1:0] data);
    logic [data_width-1:0] rdata;
    logic                  err;
    mmio_access(write, addr, data, rdata, err);
    check_value($sformatf("mmio_error at address %h", addr), data_width'(err), 1);
    check_value("mmio_rdata", rdata, '0);
  endtask

  task automatic run_job(input job_cmd_e inject, input logic [data_width-1:0] exp_result,
                         input logic exp_overflow);
    logic [acc_width:0]    predicted;
    logic [data_width-1:0] rdata;
    logic                  err;
    int                    waited;
    predicted = series_sum();
    check_value("pattern file result", data_width'(predicted[acc_width-1:0]), exp_result);
    check_value("pattern file overflow", data_width'(predicted[acc_width]),
                data_width'(exp_overflow));
    @(negedge clock);
    job_valid   = 1'b1;
    job_command = JOB_START;
    @(negedge clock);
    check_value("job_running", data_width'(job_running), 1);
    // Second command lands while the job is in flight
    job_command = inject;
    @(negedge clock);
    job_valid   = 1'b0;
    job_command = JOB_NOP;
    waited      = 0;
    while (!job_done) begin
      assert (waited < int'(count_model) + 16) else
        report_failure($sformatf("job_done never pulsed after start at %0t", $time));
      @(negedge clock);
      waited++;
    end
    check_value("job_running", data_width'(job_running), 0);
    mmio_access(1'b0, REG_RESULT, '0, rdata, err);
    check_value("mmio_error", data_width'(err), '0);
    check_value("REG_RESULT", rdata, exp_result);
    mmio_access(1'b0, REG_ERROR, '0, rdata, err);
    check_value("REG_ERROR overflow bit", data_width'(rdata[ERR_ACC_OVERFLOW]),
                data_width'(exp_overflow));
  endtask

  // Start a job first so the soft reset has one to cancel
  task automatic soft_reset_job();
    @(negedge clock);
    job_valid   = 1'b1;
    job_command = JOB_START;
    @(negedge clock);
    check_value("job_running", data_width'(job_running), 1);
    job_command = JOB_RESET;
    @(negedge clock);
    job_valid   = 1'b0;
    job_command = JOB_NOP;
    // Pulse, counter load, hold time and one spare cycle
    repeat (`AFU_SOFT_RESET_CYCLES + 3) @(negedge clock);
    check_value("job_running", data_width'(job_running), 0);
    base_model   = '0;
    stride_model = '0;
    count_model  = '0;
  endtask

  task automatic illegal_command();
    logic [1:0] code;
    code = 2'b11;
    @(negedge clock);
    job_valid   = 1'b1;
    job_command = job_cmd_e'(code);
    @(negedge clock);
    job_valid   = 1'b0;
    job_command = JOB_NOP;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                    idx;
    logic [3:0]            op;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic                  flag;
    rst_n           = 1'b1;
    job_valid       = 1'b0;
    job_command     = JOB_NOP;
    mmio_valid      = 1'b0;
    mmio_write      = 1'b0;
    mmio_address    = '0;
    mmio_wdata      = '0;
    base_model      = '0;
    stride_model    = '0;
    count_model     = '0;
    patterns_loaded = 1'b0;
    $readmemh("testbench/afu_patterns.txt", pattern_mem);
    pattern_count = 0;
    while (pattern_count < max_patterns &&
           pattern_mem[4*pattern_count][3:0] != op_end) begin
      pattern_count++;
    end
    patterns_loaded = 1'b1;
    // Real falling edge so the asynchronous reset fires
    #1 rst_n = 1'b0;
    repeat (5) @(negedge clock);
    rst_n = 1'b1;
    // Two synchronizer stages before the internal reset lifts
    repeat (3) @(negedge clock);
    for (idx = 0; idx < pattern_count; idx++) begin
      op   = pattern_mem[4*idx][3:0];
      addr = pattern_mem[4*idx+1][addr_width-1:0];
      data = pattern_mem[4*idx+2];
      flag = pattern_mem[4*idx+3][0];
      case (op)
        op_write:   write_register(addr, data);
        op_read:    read_register(addr, data);
        op_bad:     bad_access(flag, addr, data);
        op_start:   run_job(job_cmd_e'(addr[1:0]), data, flag);
        op_soft:    soft_reset_job();
        op_illegal: illegal_command();
        default:
          report_failure($sformatf("unknown pattern opcode %h in pattern %0d", op, idx));
      endcase
    end
    @(negedge clock);
    $display("TEST OK");
    $finish;
  end

  initial begin
    longint limit;
    wait (patterns_loaded);
    limit = longint'(pattern_count) * 200 + 2000;
    #(limit);
    $display("watchdog timeout at %0t, the patterns did not finish", $time);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
